// File: hdl/isa_pkg.sv
package isa_pkg;

    localparam int isa_width = 32;                  // instruction and address width
    localparam int op_width = 6;                    // primary opcode field
    localparam int reg_width = 5;                   // register index field
    localparam int imm_width = 16;                  // i-type immediate
    localparam int target_width = 26;               // j-type word target

    // jump opcodes, the ones fetch resolves on its own
    localparam logic [op_width-1:0] op_j = 6'h02;   // j target
    localparam logic [op_width-1:0] op_jal = 6'h03; // jal target, links r31 later

    // i-type view: opcode rs rt imm
    typedef struct packed {
        logic [op_width-1:0] opcode;
        logic [reg_width-1:0] rs;
        logic [reg_width-1:0] rt;
        logic [imm_width-1:0] imm;
    } i_fmt_t;

    // j-type view: opcode target
    typedef struct packed {
        logic [op_width-1:0] opcode;
        logic [target_width-1:0] target;            // word target, shifted by 2 when used
    } j_fmt_t;

    // one instruction word, decoded as whichever format the opcode says
    typedef union packed {
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } isa_word_u;

endpackage

// File: hdl/fetch_pkg.sv
package fetch_pkg;
    import isa_pkg::*;

    // load stream address: byte address, top used bit selects dmem
    localparam int load_addr_width = 16;                 // holds ROM_DEPTH up to 13
    localparam int dmem_addr_width = load_addr_width - 2; // word address, byte bits stripped

    localparam logic [isa_width-1:0] reset_pc = '0;      // fetch restarts here after loading
    localparam logic [isa_width-1:0] pc_step = 32'd4;    // one word in bytes

    // redirect from execute or from the jump predecoder
    typedef struct packed {
        logic offset_en;                                 // relative branch taken
        logic [isa_width-1:0] offset;                    // in words, from pc+4
        logic overload_en;                               // absolute jump taken
        logic [isa_width-1:0] target;                    // byte address
    } redirect_t;

    // one fetched instruction towards decode
    typedef struct packed {
        logic [isa_width-1:0] pc;                        // byte address of instr
        isa_word_u instr;
    } fetch_out_t;

    // one word from the program loader
    typedef struct packed {
        logic [load_addr_width-1:0] addr;                // byte address, bit ROM_DEPTH+2 = dmem
        logic [isa_width-1:0] data;
    } load_word_t;

    // one data memory write leaving the subsystem
    typedef struct packed {
        logic [dmem_addr_width-1:0] addr;                // word address inside dmem
        logic [isa_width-1:0] data;
    } dmem_write_t;

endpackage

// File: hdl/inst_rom.sv
`timescale 1ns/1ps

module inst_rom import isa_pkg::*; #(
    parameter int ROM_DEPTH = 10                 // log2 of words
) (
    input  logic                 clk,
    input  logic                 ena,            // no access at all when low
    input  logic                 we,             // write, only with ena
    input  logic [ROM_DEPTH-1:0] addr,           // word address
    input  logic [isa_width-1:0] wdata,
    output logic [isa_width-1:0] rdata           // registered read data
);

    logic [isa_width-1:0] mem [2**ROM_DEPTH];

    // single port, read-first, one cycle read latency
    always_ff @(posedge clk) begin
        if (ena) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];                  // old word on a write cycle
        end
    end

endmodule

// File: hdl/instruction_mem.sv
`timescale 1ns/1ps

module instruction_mem import isa_pkg::*; import fetch_pkg::*; #(
    parameter int ROM_DEPTH = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_hold,     // loader owns the ram
    input  logic                 no_op,          // kill the output stage
    input  logic                 pc_reset,       // restart at reset_pc
    input  logic                 imem_we,        // loader write strobe
    input  logic [ROM_DEPTH-1:0] imem_addr,
    input  logic [isa_width-1:0] imem_data,
    input  logic                 redirect_valid,
    input  redirect_t            redirect,       // for the transferred instr
    output logic                 out_valid,
    input  logic                 out_ready,
    output fetch_out_t           out_data
);

    logic [isa_width-1:0] pc;                    // next pc to read, one ahead
    logic [isa_width-1:0] pc_next;
    logic [isa_width-1:0] out_pc;                // pc of the presented instr
    logic [isa_width-1:0] rom_rdata;
    logic                 advance;               // output stage may take a new word
    logic                 transfer;              // decode takes the presented word
    logic                 fetch_en;
    logic                 take_redirect;
    logic                 rom_ena;
    logic                 rom_we;
    logic [ROM_DEPTH-1:0] rom_addr;

    assign advance = ~out_valid | out_ready;
    assign transfer = out_valid & out_ready;
    assign fetch_en = ~fetch_hold & ~no_op & advance;
    assign take_redirect = transfer & redirect_valid; // only with its own instr

    // next pc, highest priority first
    always_comb begin
        if (pc_reset) begin
            pc_next = reset_pc;
        end else if (take_redirect && redirect.overload_en) begin
            pc_next = redirect.target;           // absolute jump
        end else if (take_redirect && redirect.offset_en) begin
            pc_next = out_pc + pc_step + (redirect.offset << 2); // relative to delay slot
        end else begin
            pc_next = pc + pc_step;
        end
    end

    // ram port goes to the loader while held
    assign rom_addr = fetch_hold ? imem_addr : pc[ROM_DEPTH+1:2]; // pc is in bytes
    assign rom_we = fetch_hold & imem_we;
    assign rom_ena = fetch_hold ? imem_we : fetch_en; // frozen under back-pressure

    inst_rom #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_rom (
        .clk   (clk),
        .ena   (rom_ena),
        .we    (rom_we),
        .addr  (rom_addr),
        .wdata (imem_data),
        .rdata (rom_rdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
            out_valid <= 1'b0;
        end else begin
            if (pc_reset || fetch_en) begin
                pc <= pc_next;
            end
            if (no_op) begin
                out_valid <= 1'b0;               // bubble towards decode
            end else if (advance) begin
                out_valid <= fetch_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            out_pc <= pc;                        // follows the ram read
        end
    end

    assign out_data = '{pc: out_pc, instr: rom_rdata};

    // a held word must not change, ram and pc together
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !no_op |=> out_valid && $stable(out_data));

endmodule

// File: hdl/jump_predecode.sv
`timescale 1ns/1ps

module jump_predecode import isa_pkg::*; import fetch_pkg::*; (
    input  logic       out_valid,
    input  logic       out_ready,
    input  fetch_out_t out_data,
    output logic       jump_valid,               // j or jal being transferred
    output redirect_t  jump_redirect
);

    logic                 is_jump;
    logic [isa_width-1:0] link_pc;               // pc of the delay slot

    assign link_pc = out_data.pc + pc_step;
    assign is_jump = (out_data.instr.j_fmt.opcode == op_j) ||
                     (out_data.instr.j_fmt.opcode == op_jal);
    assign jump_valid = out_valid & out_ready & is_jump;

    // target keeps the region bits of the delay slot pc
    assign jump_redirect.offset_en = 1'b0;
    assign jump_redirect.offset = '0;
    assign jump_redirect.overload_en = is_jump;
    assign jump_redirect.target = {link_pc[isa_width-1 -: 4],
                                   out_data.instr.j_fmt.target, 2'b00};

endmodule

// File: hdl/uart_loader.sv
`timescale 1ns/1ps

module uart_loader import isa_pkg::*; import fetch_pkg::*; #(
    parameter int ROM_DEPTH = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_grant,     // from hazard_unit
    input  logic                 load_valid,
    input  load_word_t           load_word,
    output logic                 load_ready,
    output logic                 imem_we,        // straight into the ram
    output logic [ROM_DEPTH-1:0] imem_addr,
    output logic [isa_width-1:0] imem_data,
    output logic                 dmem_valid,
    output dmem_write_t          dmem_write
);

    logic accept;
    logic to_dmem;                               // upper half of the load map

    assign load_ready = load_grant;              // only while loading
    assign accept = load_valid & load_ready;
    assign to_dmem = load_word.addr[ROM_DEPTH+2];

    // imem write goes out in the same cycle, ram is still held by the loader
    assign imem_we = accept & ~to_dmem;
    assign imem_addr = load_word.addr[ROM_DEPTH+1:2]; // strip byte bits
    assign imem_data = load_word.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem_valid <= 1'b0;
        end else begin
            dmem_valid <= accept & to_dmem;      // one pulse per word
        end
    end

    always_ff @(posedge clk) begin
        if (accept && to_dmem) begin
            dmem_write <= '{addr: dmem_addr_width'(load_word.addr[ROM_DEPTH+1:2]),
                            data: load_word.data};
        end
    end

    // every dmem write stems from a granted transfer
    a_dmem_granted: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid |-> $past(load_grant));

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic prog_mode,                      // external load request
    output logic load_grant,                     // loader may take words
    output logic fetch_hold,                     // ram and pc belong to loader
    output logic no_op,                          // output stage invalid
    output logic pc_reset                        // one pulse after loading
);

    logic prog_q;                                // registered prog_mode

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_q <= 1'b0;
            pc_reset <= 1'b0;
        end else begin
            prog_q <= prog_mode;
            pc_reset <= prog_q & ~prog_mode;     // falling edge
        end
    end

    assign load_grant = prog_q;
    assign fetch_hold = prog_q;
    assign no_op = prog_q | pc_reset;            // bubble through the restart

    // restart only once the loader has let go
    a_reset_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        pc_reset |-> !load_grant && $past(load_grant));

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import isa_pkg::*; import fetch_pkg::*; #(
    parameter int ROM_DEPTH = 10                 // log2 of imem words
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        prog_mode,
    input  logic        load_valid,
    input  load_word_t  load_word,
    output logic        load_ready,
    output logic        out_valid,
    input  logic        out_ready,
    output fetch_out_t  out_data,
    input  logic        redirect_valid,          // from execute
    input  redirect_t   redirect,
    output logic        dmem_valid,
    output dmem_write_t dmem_write
);

    logic                 load_grant;
    logic                 fetch_hold;
    logic                 no_op;
    logic                 pc_reset;
    logic                 imem_we;
    logic [ROM_DEPTH-1:0] imem_addr;
    logic [isa_width-1:0] imem_data;
    logic                 jump_valid;
    redirect_t            jump_redirect;
    logic                 fe_redirect_valid;     // merged redirect
    redirect_t            fe_redirect;

    // execute wins over the predecoded jump
    assign fe_redirect_valid = redirect_valid | jump_valid;
    assign fe_redirect = redirect_valid ? redirect : jump_redirect;

    hazard_unit u_hazard (
        .clk        (clk),
        .rst_n      (rst_n),
        .prog_mode  (prog_mode),
        .load_grant (load_grant),
        .fetch_hold (fetch_hold),
        .no_op      (no_op),
        .pc_reset   (pc_reset)
    );

    uart_loader #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_grant (load_grant),
        .load_valid (load_valid),
        .load_word  (load_word),
        .load_ready (load_ready),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_valid (dmem_valid),
        .dmem_write (dmem_write)
    );

    instruction_mem #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_imem (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_hold     (fetch_hold),
        .no_op          (no_op),
        .pc_reset       (pc_reset),
        .imem_we        (imem_we),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .redirect_valid (fe_redirect_valid),
        .redirect       (fe_redirect),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_data       (out_data)
    );

    jump_predecode u_jump (
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .jump_valid    (jump_valid),
        .jump_redirect (jump_redirect)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100                // full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;     // 50/50 duty
    end

endmodule

// File: tests/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker import isa_pkg::*; import fetch_pkg::*; #(
    parameter int ROM_DEPTH = 6
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        prog_mode,
    input  logic        load_valid,
    input  logic        load_ready,
    input  load_word_t  load_word,
    input  logic        out_valid,
    input  logic        out_ready,
    input  fetch_out_t  out_data,
    input  logic        redirect_valid,
    input  redirect_t   redirect,
    input  logic        dmem_valid,
    input  dmem_write_t dmem_write,
    input  logic        end_check,               // one pulse when stimulus is over
    output int          checked,                 // transfers compared
    output int          dmem_seen,
    output int          errors
);

    isa_word_u   image [2**ROM_DEPTH];           // imem as the load stream wrote it
    dmem_write_t dmem_q [$];                     // dmem writes still owed
    dmem_write_t exp_w;
    logic [31:0] exp_pc;                         // pc due on the output next
    logic [31:0] exp_after;                      // pc fetched behind it
    logic [31:0] nxt;
    logic        loaded;
    logic        held;
    fetch_out_t  held_data;
    logic        rst_q;

    // pc that follows a transfer: external redirect first, then a j/jal, then +4
    function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc_reg,
            input logic [31:0] xfer_pc, input isa_word_u instr,
            input logic ext_valid, input redirect_t ext);
        logic [31:0] slot_pc;
        slot_pc = xfer_pc + 32'd4;               // delay slot
        if (ext_valid && ext.overload_en)
            return ext.target;
        else if (ext_valid && ext.offset_en)
            return slot_pc + (ext.offset << 2);  // offset counts words
        else if (ext_valid)
            return pc_reg + 32'd4;               // external wins, even when empty
        else if (instr.j_fmt.opcode == op_j || instr.j_fmt.opcode == op_jal)
            return {slot_pc[31:28], instr.j_fmt.target, 2'b00};
        else
            return pc_reg + 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (!rst_q && (out_valid || load_ready || dmem_valid)) begin
                $display("reset left out_valid, load_ready or dmem_valid high");
                errors++;
            end
            held = 1'b0;
        end else begin
            if (load_valid && load_ready) begin  // mirror the load map
                if (load_word.addr[ROM_DEPTH+2])
                    dmem_q.push_back('{addr: dmem_addr_width'(load_word.addr[ROM_DEPTH+1:2]),
                                       data: load_word.data});
                else
                    image[load_word.addr[ROM_DEPTH+1:2]] = load_word.data;
            end
            if (dmem_valid) begin
                dmem_seen <= dmem_seen + 1;
                if (dmem_q.size() == 0) begin
                    $display("dmem write without a load word behind it");
                    errors++;
                end else begin
                    exp_w = dmem_q.pop_front();
                    check_value("dmem_write.addr", 32'(dmem_write.addr), 32'(exp_w.addr));
                    check_value("dmem_write.data", dmem_write.data, exp_w.data);
                end
            end
            if (prog_mode) begin                 // fetch restarts at 0 after loading
                loaded = 1'b1;
                exp_pc = '0;
                exp_after = 32'd4;
                held = 1'b0;
            end else if (loaded) begin
                if (held && (!out_valid || out_data !== held_data)) begin
                    $display("FAILED out_data held: got %h, expected %h",
                             out_data, held_data);
                    errors++;
                end
                if (out_valid && out_ready) begin
                    check_value("out_data.pc", out_data.pc, exp_pc);
                    check_value("out_data.instr", out_data.instr,
                                image[exp_pc[ROM_DEPTH+1:2]]);
                    nxt = next_fetch_pc(exp_after, exp_pc, image[exp_pc[ROM_DEPTH+1:2]],
                                        redirect_valid, redirect);
                    exp_pc = exp_after;          // delay slot comes out next
                    exp_after = nxt;
                    checked <= checked + 1;
                end
                held = out_valid && !out_ready;
                held_data = out_data;
            end
            if (end_check && dmem_q.size() != 0) begin
                $display("%0d dmem writes never came out", dmem_q.size());
                errors++;
            end
        end
        rst_q = rst_n;
    end

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import isa_pkg::*; import fetch_pkg::*; ();

    localparam int rom_depth = 6;
    localparam int words = 2**rom_depth;
    localparam int dmem_words = words / 8;       // one per eight imem words
    localparam int n_fetch = 400;
    localparam int max_stall = 3;                // longest run of out_ready low
    localparam int max_gap = 2;                  // idle cycles between load words
    localparam int timeout_cycles =
        2 * (20 + (words + dmem_words) * (max_gap + 1) + n_fetch * (max_stall + 1));

    logic        clk;
    logic        rst_n;
    logic        prog_mode;
    logic        load_valid;
    logic        load_ready;
    logic        out_valid;
    logic        out_ready;
    logic        redirect_valid;
    logic        dmem_valid;
    logic        end_check;
    load_word_t  load_word;
    fetch_out_t  out_data;
    redirect_t   redirect;
    dmem_write_t dmem_write;
    int          checked;
    int          dmem_seen;
    int          errors;

    tb_clock #(.period_ns(100)) u_clock (.clk(clk));

    fetch_top #(.ROM_DEPTH(rom_depth)) UUT (.*);

    fetch_checker #(.ROM_DEPTH(rom_depth)) u_checker (.*);

    // random word, with a j or jal at fixed slots
    function automatic logic [31:0] image_word(input int idx);
        isa_word_u w;
        w = $urandom;
        if (w.j_fmt.opcode == op_j || w.j_fmt.opcode == op_jal)
            w.j_fmt.opcode = 6'h08;              // no jumps by accident
        if (idx % 7 == 3) begin
            w.j_fmt.opcode = (idx % 2 == 1) ? op_jal : op_j;
            w.j_fmt.target = 26'($urandom % words);
        end
        return w;
    endfunction

    task automatic send_word(input logic [15:0] addr, input logic [31:0] data);
        load_valid <= 1'b1;
        load_word <= '{addr: addr, data: data};
        @(posedge clk);
        while (!load_ready)
            @(posedge clk);
        load_valid <= 1'b0;
        repeat ($urandom % (max_gap + 1)) @(posedge clk);
    endtask

    initial begin
        redirect_t r;
        int        stall;
        void'($urandom(32'h2095dfb2));
        rst_n <= 1'b0;
        prog_mode <= 1'b1;                       // load straight after reset
        load_valid <= 1'b0;
        load_word <= '0;
        out_ready <= 1'b1;
        redirect_valid <= 1'b0;
        redirect <= '0;
        end_check <= 1'b0;
        stall = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < words; i++) begin   // byte bits random, dmem words mixed in
            send_word(16'(i * 4 + $urandom % 4), image_word(i));
            if (i % 8 == 5)
                send_word(16'((1 << (rom_depth + 2)) + (i / 8) * 4 + $urandom % 4), $urandom);
        end
        prog_mode <= 1'b0;
        while (checked < n_fetch) begin
            @(posedge clk);
            if (stall >= max_stall || $urandom % 4 != 0) begin
                out_ready <= 1'b1;
                stall = 0;
            end else begin
                out_ready <= 1'b0;
                stall++;
            end
            r.overload_en = ($urandom % 2 == 0);
            r.offset_en = ~r.overload_en | ($urandom % 4 == 0); // both now and then
            r.target = 32'(($urandom % words) * 4);
            r.offset = 32'(int'($urandom % 16) - 8);
            redirect <= r;
            redirect_valid <= ($urandom % 8 == 0);
        end
        out_ready <= 1'b1;
        redirect_valid <= 1'b0;
        end_check <= 1'b1;
        @(posedge clk);
        end_check <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        $display("fetches checked %0d, dmem writes %0d, errors %0d",
                 checked, dmem_seen, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, fetch stalled", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: verilog.f
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/inst_rom.sv
hdl/instruction_mem.sv
hdl/jump_predecode.sv
hdl/uart_loader.sv
hdl/hazard_unit.sv
hdl/fetch_top.sv
tests/tb_clock.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_tb -f verilog.f -o fetch_sim \
    && ./obj_dir/fetch_sim | tee sim.log \
    || echo "build or simulation did not complete"
grep -qx "Regression passed" sim.log && exit 0 || exit 1
